// File: list.f
source/mem_request_pkg.sv
source/cu_setup_pkg.sv
source/request_push_if.sv
source/request_pop_if.sv
source/setup_sequencer.sv
source/request_fifo.sv
source/request_issue.sv
source/cu_setup.sv
bench/tb_clock.sv
bench/cu_setup_tb.sv

// File: bench/cu_setup_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cu_setup_tb;

// Six tests, the back-pressure run the longest, plus margin
localparam int unsigned TIMEOUT_CYCLES = 4000;

logic                                  ap_clk;
logic                                  areset_cu_setup;
logic                                  descriptor_valid;
logic [cu_setup_pkg::SETUP_WORD_W-1:0] descriptor_word;
logic                                  cu_flush;
logic                                  request_ready;
logic                                  response_valid = 1'b0;
logic                                  request_valid;
logic [mem_request_pkg::CMD_W-1:0]     request_cmd;
logic [mem_request_pkg::ADDR_W-1:0]    request_address;
logic                                  done;

logic [mem_request_pkg::CMD_W-1:0]  seen_cmd[$];
logic [mem_request_pkg::ADDR_W-1:0] seen_addr[$];
int unsigned                        due_q[$];
int unsigned                        responses_sent = 0;
int unsigned                        cycle = 0;
logic                               hold_responses = 1'b0;

tb_clock clock_gen (
    .ap_clk(ap_clk)
);

cu_setup cu_setup_i (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .descriptor_valid(descriptor_valid),
    .descriptor_word (descriptor_word),
    .cu_flush        (cu_flush),
    .request_ready   (request_ready),
    .response_valid  (response_valid),
    .request_valid   (request_valid),
    .request_cmd     (request_cmd),
    .request_address (request_address),
    .done            (done)
);

// --------------------
// Monitor and memory responder
// --------------------
always @(negedge ap_clk) begin : respond
    int unsigned due;
    if (areset_cu_setup) begin
        response_valid = 1'b0;
    end else begin
        if (request_valid) begin
            seen_cmd.push_back(request_cmd);
            seen_addr.push_back(request_address);
            // Answers stay in order, at most one per cycle
            due = cycle + $urandom_range(1, 4);
            if (due_q.size() > 0 && due <= due_q[$]) begin
                due = due_q[$] + 1;
            end
            due_q.push_back(due);
        end
        if (!hold_responses && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            responses_sent = responses_sent + 1;
            response_valid = 1'b1;
        end else begin
            response_valid = 1'b0;
        end
    end
end

always @(posedge ap_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
        $display("Run stopped after %0d cycles with tests still running", cycle);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end
end

// --------------------
// Helpers
// --------------------
task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    if (actual !== expected) begin
        $display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, actual, expected);
        $display("SOME TESTS FAILED");
        $fatal(1);
    end
endtask

task automatic apply_reset();
    @(negedge ap_clk);
    areset_cu_setup  = 1'b1;
    descriptor_valid = 1'b0;
    descriptor_word  = '0;
    cu_flush         = 1'b0;
    request_ready    = 1'b1;
    hold_responses   = 1'b0;
    repeat (4) @(negedge ap_clk);
    seen_cmd.delete();
    seen_addr.delete();
    due_q.delete();
    responses_sent  = 0;
    areset_cu_setup = 1'b0;
endtask

task automatic send_descriptor(input int program_beats, input int flush_beats,
                               input logic flush_enable);
    logic [cu_setup_pkg::SETUP_WORD_W-1:0] word;
    word = '0;
    word = word | (program_beats << cu_setup_pkg::PROGRAM_COUNT_LSB);
    word = word | (flush_beats << cu_setup_pkg::FLUSH_COUNT_LSB);
    word[cu_setup_pkg::FLUSH_ENABLE_BIT] = flush_enable;
    @(negedge ap_clk);
    descriptor_valid = 1'b1;
    descriptor_word  = word;
    @(negedge ap_clk);
    descriptor_valid = 1'b0;
endtask

task automatic wait_for_done();
    while (!done) begin
        @(negedge ap_clk);
    end
endtask

task automatic wait_for_responses(input int count);
    while (responses_sent < count) begin
        @(negedge ap_clk);
    end
endtask

// Beats of one run, ascending from address zero
task automatic expect_requests(input int first, input int count,
                               input logic [mem_request_pkg::CMD_W-1:0] cmd);
    for (int i = 0; i < count; i++) begin
        check_value("request_cmd", seen_cmd[first + i], cmd);
        check_value("request_address", seen_addr[first + i],
                    i * mem_request_pkg::BEAT_BYTES);
    end
endtask

// --------------------
// Directed tests
// --------------------
task automatic read_only_run();
    apply_reset();
    send_descriptor(5, 0, 1'b0);
    wait_for_done();
    check_value("responses at done", responses_sent, 5);
    repeat (10) begin
        @(negedge ap_clk);
        check_value("done", done, 1'b1);
    end
    check_value("request count", seen_addr.size(), 5);
    expect_requests(0, 5, mem_request_pkg::CMD_MEM_READ);
endtask

task automatic read_then_flush();
    apply_reset();
    send_descriptor(3, 4, 1'b1);
    wait_for_responses(3);
    repeat (20) @(negedge ap_clk);
    check_value("request count before flush", seen_addr.size(), 3);
    check_value("done", done, 1'b0);
    cu_flush = 1'b1;
    wait_for_done();
    cu_flush = 1'b0;
    check_value("responses at done", responses_sent, 7);
    check_value("request count", seen_addr.size(), 7);
    expect_requests(0, 3, mem_request_pkg::CMD_MEM_READ);
    expect_requests(3, 4, mem_request_pkg::CMD_CACHE_FLUSH);
endtask

task automatic backpressure_run();
    apply_reset();
    request_ready = 1'b0;
    send_descriptor(40, 0, 1'b0);
    repeat (100) @(negedge ap_clk);
    check_value("request count while stalled", seen_addr.size(), 0);
    while (!done) begin
        request_ready = $urandom_range(0, 1);
        @(negedge ap_clk);
    end
    request_ready = 1'b1;
    check_value("request count", seen_addr.size(), 40);
    expect_requests(0, 40, mem_request_pkg::CMD_MEM_READ);
endtask

task automatic done_waits_responses();
    apply_reset();
    hold_responses = 1'b1;
    send_descriptor(2, 0, 1'b0);
    while (seen_addr.size() < 2) begin
        @(negedge ap_clk);
    end
    repeat (50) begin
        @(negedge ap_clk);
        check_value("done", done, 1'b0);
    end
    hold_responses = 1'b0;
    wait_for_done();
    check_value("responses at done", responses_sent, 2);
    expect_requests(0, 2, mem_request_pkg::CMD_MEM_READ);
endtask

task automatic flush_waits_command();
    apply_reset();
    send_descriptor(3, 2, 1'b1);
    wait_for_responses(3);
    repeat (50) begin
        @(negedge ap_clk);
        check_value("done", done, 1'b0);
        check_value("request count", seen_addr.size(), 3);
    end
endtask

task automatic zero_count_run();
    apply_reset();
    send_descriptor(0, 0, 1'b0);
    wait_for_done();
    repeat (10) @(negedge ap_clk);
    check_value("request count", seen_addr.size(), 0);
    check_value("done", done, 1'b1);
endtask

initial begin
    areset_cu_setup  = 1'b1;
    descriptor_valid = 1'b0;
    descriptor_word  = '0;
    cu_flush         = 1'b0;
    request_ready    = 1'b1;
    void'($urandom(80));

    read_only_run();
    read_then_flush();
    backpressure_run();
    done_waits_responses();
    flush_waits_command();
    zero_count_run();

    $display("ALL TESTS PASSED");
    $finish;
end

endmodule : cu_setup_tb

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic ap_clk
);

// 8 ns period
localparam realtime HALF_PERIOD = 4.0;

initial begin
    ap_clk = 1'b0;
end

always begin
    #HALF_PERIOD ap_clk = ~ap_clk;
end

endmodule : tb_clock

`default_nettype wire

// File: source/cu_setup.sv
`timescale 1ns/1ps
`default_nettype none

module cu_setup (
    input  wire logic                                  ap_clk,
    input  wire logic                                  areset_cu_setup,
    input  wire logic                                  descriptor_valid,
    input  wire logic [cu_setup_pkg::SETUP_WORD_W-1:0] descriptor_word,
    input  wire logic                                  cu_flush,
    input  wire logic                                  request_ready,
    input  wire logic                                  response_valid,
    output logic                                       request_valid,
    output logic [mem_request_pkg::CMD_W-1:0]          request_cmd,
    output logic [mem_request_pkg::ADDR_W-1:0]         request_address,
    output logic                                       done
);

logic drained;

request_push_if push_bus ();
request_pop_if  pop_bus ();

// --------------------
// Generator
// --------------------
setup_sequencer setup_sequencer_i (
    .ap_clk          (ap_clk),
    .areset_cu_setup (areset_cu_setup),
    .descriptor_valid(descriptor_valid),
    .descriptor_word (descriptor_word),
    .cu_flush        (cu_flush),
    .drained         (drained),
    .push            (push_bus.producer),
    .done            (done)
);

// Request queue between generator and memory side
request_fifo request_fifo_i (
    .ap_clk         (ap_clk),
    .areset_cu_setup(areset_cu_setup),
    .push           (push_bus.buffer),
    .pop            (pop_bus.buffer)
);

// --------------------
// Memory side
// --------------------
request_issue request_issue_i (
    .ap_clk         (ap_clk),
    .areset_cu_setup(areset_cu_setup),
    .pop            (pop_bus.consumer),
    .request_ready  (request_ready),
    .response_valid (response_valid),
    .request_valid  (request_valid),
    .request_cmd    (request_cmd),
    .request_address(request_address),
    .drained        (drained)
);

endmodule : cu_setup

`default_nettype wire

// File: source/request_issue.sv
`timescale 1ns/1ps
`default_nettype none

module request_issue (
    input  wire logic                             ap_clk,
    input  wire logic                             areset_cu_setup,
    request_pop_if.consumer                       pop,
    input  wire logic                             request_ready,
    input  wire logic                             response_valid,
    output logic                                  request_valid,
    output logic [mem_request_pkg::CMD_W-1:0]     request_cmd,
    output logic [mem_request_pkg::ADDR_W-1:0]    request_address,
    output logic                                  drained
);

logic [cu_setup_pkg::COUNT_W-1:0] outstanding;

// Ready level drains the FIFO one entry per cycle
assign pop.take = pop.valid && request_ready;

// --------------------
// Request outputs
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        request_valid <= 1'b0;
    end else begin
        request_valid <= pop.take;
    end
end

always_ff @(posedge ap_clk) begin
    if (pop.take) begin
        request_cmd     <= pop.cmd;
        request_address <= pop.address;
    end
end

// --------------------
// Outstanding count
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        outstanding <= '0;
    end else begin
        case ({pop.take, response_valid})
            2'b10:   outstanding <= outstanding + 1'b1;
            2'b01:   outstanding <= outstanding - 1'b1;
            default: outstanding <= outstanding;
        endcase
    end
end

// Nothing queued and every issued request answered
assign drained = !pop.valid && (outstanding == '0);

assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
    response_valid |-> (outstanding != '0))
    else $error("request_issue: response with no request outstanding");

endmodule : request_issue

`default_nettype wire

// File: source/request_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module request_fifo (
    input  wire logic      ap_clk,
    input  wire logic      areset_cu_setup,
    request_push_if.buffer push,
    request_pop_if.buffer  pop
);

logic [mem_request_pkg::CMD_W-1:0]           cmd_mem  [cu_setup_pkg::FIFO_DEPTH];
logic [mem_request_pkg::ADDR_W-1:0]          addr_mem [cu_setup_pkg::FIFO_DEPTH];
logic [$clog2(cu_setup_pkg::FIFO_DEPTH)-1:0] wr_ptr;
logic [$clog2(cu_setup_pkg::FIFO_DEPTH)-1:0] rd_ptr;
logic [$clog2(cu_setup_pkg::FIFO_DEPTH):0]   fill_count;
logic                                        pop_fire;

assign pop_fire = pop.valid && pop.take;

// Storage
always_ff @(posedge ap_clk) begin
    if (push.valid) begin
        cmd_mem[wr_ptr]  <= push.cmd;
        addr_mem[wr_ptr] <= push.address;
    end
end

// Pointers wrap on their own, depth is a power of two
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        wr_ptr     <= '0;
        rd_ptr     <= '0;
        fill_count <= '0;
    end else begin
        if (push.valid) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
        if (pop_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
        case ({push.valid, pop_fire})
            2'b10:   fill_count <= fill_count + 1'b1;
            2'b01:   fill_count <= fill_count - 1'b1;
            default: fill_count <= fill_count;
        endcase
    end
end

// Show-ahead head entry
assign pop.valid   = (fill_count != '0);
assign pop.cmd     = cmd_mem[rd_ptr];
assign pop.address = addr_mem[rd_ptr];

assign push.prog_full = (fill_count >= cu_setup_pkg::PROG_THRESH);

assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
    push.valid |-> (fill_count != cu_setup_pkg::FIFO_DEPTH))
    else $error("request_fifo: push into a full FIFO");

assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
    pop.take |-> pop.valid)
    else $error("request_fifo: take from an empty FIFO");

endmodule : request_fifo

`default_nettype wire

// File: source/setup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module setup_sequencer (
    input  wire logic                                  ap_clk,
    input  wire logic                                  areset_cu_setup,
    input  wire logic                                  descriptor_valid,
    input  wire logic [cu_setup_pkg::SETUP_WORD_W-1:0] descriptor_word,
    input  wire logic                                  cu_flush,
    input  wire logic                                  drained,
    request_push_if.producer                           push,
    output logic                                       done
);

logic                                  descriptor_valid_q;
logic [cu_setup_pkg::SETUP_WORD_W-1:0] setup_word;
logic [cu_setup_pkg::STATE_W-1:0]      state;
logic [cu_setup_pkg::COUNT_W-1:0]      beat_index;
logic [cu_setup_pkg::COUNT_W-1:0]      program_count;
logic [cu_setup_pkg::COUNT_W-1:0]      flush_count;
logic [cu_setup_pkg::COUNT_W-1:0]      phase_count;
logic [mem_request_pkg::ADDR_W-1:0]    beat_address;
logic                                  flush_phase;
logic                                  last_beat;

// --------------------
// Descriptor capture
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        descriptor_valid_q <= 1'b0;
    end else begin
        descriptor_valid_q <= descriptor_valid && (state == cu_setup_pkg::STATE_IDLE);
    end
end

// Only one descriptor per run is taken
always_ff @(posedge ap_clk) begin
    if (descriptor_valid && (state == cu_setup_pkg::STATE_IDLE)) begin
        setup_word <= descriptor_word;
    end
end

// Beat counts zero extended to the counter width
always_comb begin
    program_count = '0;
    program_count[cu_setup_pkg::PROGRAM_COUNT_MSB-cu_setup_pkg::PROGRAM_COUNT_LSB:0] =
        setup_word[cu_setup_pkg::PROGRAM_COUNT_MSB:cu_setup_pkg::PROGRAM_COUNT_LSB];
    flush_count = '0;
    flush_count[cu_setup_pkg::FLUSH_COUNT_MSB-cu_setup_pkg::FLUSH_COUNT_LSB:0] =
        setup_word[cu_setup_pkg::FLUSH_COUNT_MSB:cu_setup_pkg::FLUSH_COUNT_LSB];
end

// --------------------
// Request generator
// --------------------
assign flush_phase = (state == cu_setup_pkg::STATE_FLUSH_RUN);
assign phase_count = flush_phase ? flush_count : program_count;
assign last_beat   = (beat_index == phase_count - 1'b1);

always_comb begin
    beat_address = '0;
    beat_address[cu_setup_pkg::COUNT_W-1:0] = beat_index;
end

assign push.valid   = ((state == cu_setup_pkg::STATE_READ_RUN) || flush_phase) &&
                      !push.prog_full;
assign push.cmd     = flush_phase ? mem_request_pkg::CMD_CACHE_FLUSH :
                                    mem_request_pkg::CMD_MEM_READ;
assign push.address = beat_address << mem_request_pkg::BEAT_SHIFT;

assign done = (state == cu_setup_pkg::STATE_FINISHED);

// --------------------
// Setup FSM
// --------------------
always_ff @(posedge ap_clk) begin
    if (areset_cu_setup) begin
        state      <= cu_setup_pkg::STATE_IDLE;
        beat_index <= '0;
    end else begin
        case (state)
            cu_setup_pkg::STATE_IDLE: begin
                beat_index <= '0;
                if (descriptor_valid_q) begin
                    // Empty program goes straight to the drain check
                    state <= (program_count == '0) ? cu_setup_pkg::STATE_READ_WAIT :
                                                     cu_setup_pkg::STATE_READ_RUN;
                end
            end
            cu_setup_pkg::STATE_READ_RUN: begin
                if (push.valid) begin
                    beat_index <= beat_index + 1'b1;
                    if (last_beat) begin
                        state <= cu_setup_pkg::STATE_READ_WAIT;
                    end
                end
            end
            cu_setup_pkg::STATE_READ_WAIT: begin
                beat_index <= '0;
                if (drained) begin
                    state <= setup_word[cu_setup_pkg::FLUSH_ENABLE_BIT] ?
                             cu_setup_pkg::STATE_FLUSH_HOLD : cu_setup_pkg::STATE_FINISHED;
                end
            end
            cu_setup_pkg::STATE_FLUSH_HOLD: begin
                if (cu_flush) begin
                    state <= (flush_count == '0) ? cu_setup_pkg::STATE_FLUSH_WAIT :
                                                   cu_setup_pkg::STATE_FLUSH_RUN;
                end
            end
            cu_setup_pkg::STATE_FLUSH_RUN: begin
                if (push.valid) begin
                    beat_index <= beat_index + 1'b1;
                    if (last_beat) begin
                        state <= cu_setup_pkg::STATE_FLUSH_WAIT;
                    end
                end
            end
            cu_setup_pkg::STATE_FLUSH_WAIT: begin
                if (drained) begin
                    state <= cu_setup_pkg::STATE_FINISHED;
                end
            end
            default: begin
                // Finished holds until reset
                state <= state;
            end
        endcase
    end
end

// Run phases never step past their beat count
assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
    push.valid |-> (beat_index < phase_count))
    else $error("setup_sequencer: push beyond the phase beat count");

endmodule : setup_sequencer

`default_nettype wire

// File: source/request_pop_if.sv
`timescale 1ns/1ps
`default_nettype none

interface request_pop_if;

logic                               valid;
logic [mem_request_pkg::CMD_W-1:0]  cmd;
logic [mem_request_pkg::ADDR_W-1:0] address;
logic                               take;

// FIFO read side, head entry shown ahead
modport buffer (
    output valid,
    output cmd,
    output address,
    input  take
);

// Issue stage side
modport consumer (
    input  valid,
    input  cmd,
    input  address,
    output take
);

endinterface : request_pop_if

`default_nettype wire

// File: source/request_push_if.sv
`timescale 1ns/1ps
`default_nettype none

interface request_push_if;

logic                               valid;
logic [mem_request_pkg::CMD_W-1:0]  cmd;
logic [mem_request_pkg::ADDR_W-1:0] address;
logic                               prog_full;

// Request generator side
modport producer (
    output valid,
    output cmd,
    output address,
    input  prog_full
);

// FIFO write side
modport buffer (
    input  valid,
    input  cmd,
    input  address,
    output prog_full
);

endinterface : request_push_if

`default_nettype wire

// File: source/cu_setup_pkg.sv
`default_nettype none

package cu_setup_pkg;

// --------------------
// Setup word layout
// --------------------
localparam int SETUP_WORD_W      = 32;
localparam int FLUSH_ENABLE_BIT  = 2;
localparam int PROGRAM_COUNT_LSB = 3;
localparam int PROGRAM_COUNT_MSB = 15;
localparam int FLUSH_COUNT_LSB   = 16;
localparam int FLUSH_COUNT_MSB   = 31;

// Beat and outstanding counters
localparam int COUNT_W = 16;

// Request FIFO, four entries spare above the threshold
localparam int FIFO_DEPTH  = 16;
localparam int PROG_THRESH = 12;

// --------------------
// Sequencer FSM codes
// --------------------
localparam int STATE_W = 3;

localparam logic [STATE_W-1:0] STATE_IDLE       = 3'd0;
localparam logic [STATE_W-1:0] STATE_READ_RUN   = 3'd1;
localparam logic [STATE_W-1:0] STATE_READ_WAIT  = 3'd2;
localparam logic [STATE_W-1:0] STATE_FLUSH_HOLD = 3'd3;
localparam logic [STATE_W-1:0] STATE_FLUSH_RUN  = 3'd4;
localparam logic [STATE_W-1:0] STATE_FLUSH_WAIT = 3'd5;
localparam logic [STATE_W-1:0] STATE_FINISHED   = 3'd6;

endpackage : cu_setup_pkg

`default_nettype wire

// File: source/mem_request_pkg.sv
`default_nettype none

package mem_request_pkg;

// Request word format
localparam int ADDR_W = 32;
localparam int CMD_W  = 2;

// Command codes carried with each request
localparam logic [CMD_W-1:0] CMD_MEM_READ    = 2'd1;
localparam logic [CMD_W-1:0] CMD_CACHE_FLUSH = 2'd2;

// One memory beat, index to byte address
localparam int BEAT_BYTES = 64;
localparam int BEAT_SHIFT = $clog2(BEAT_BYTES);

endpackage : mem_request_pkg

`default_nettype wire
